// ==== sources.f ====
+incdir+hw
hw/rob_pkg.sv
hw/rob_tag_alloc.sv
hw/rob_entry_table.sv
hw/rob_commit.sv
hw/rob_top.sv
tests/rob_asserts.sv
tests/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reorder buffer testbench, verdict taken from sim.log
rm -f sim.log obj_dir/rob_sim
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
    --top-module rob_tb -o rob_sim \
    && ./obj_dir/rob_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q '^NO ERRORS$' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_tb;

    localparam int WAIT_EMPTY = 0;
    localparam int WAIT_FULL  = 1;
    localparam int TIMEOUT    = 2000;

    logic                   clk, rst_n, flush;
    logic                   dispatch_valid, complete_valid, full;
    logic                   commit_valid, store_valid, redirect_valid;
    rob_pkg::rob_dispatch_t dispatch;
    rob_pkg::rob_complete_t complete;
    rob_pkg::rob_commit_t   commit;
    rob_pkg::rob_tag_t      alloc_tag, store_tag;
    logic [`PC_W-1:0]       redirect_pc;

    // model state as it will be after the next clock edge
    rob_pkg::rob_entry_t    m_ent [`ROB_DEPTH];
    rob_pkg::rob_tag_t      order [$];
    logic [`ROB_DEPTH-1:0]  m_occ = '0;
    rob_pkg::rob_tag_t      m_wr = '0;
    bit                     sq_pend = 1'b0;

    int seed = 71850;
    int errors = 0;
    int err_mark = 0;
    int test_num = 0;
    int tests_failed = 0;
    int commits = 0;
    int redirects = 0;
    bit dis_en = 1'b0;
    bit cmp_en = 1'b0;
    bit st_en = 1'b0;
    int mp_rate = 0;
    int keep_head = 0;

    rob_top rob_top_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input rob_pkg::rob_tag_t got,
                             input rob_pkg::rob_tag_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_commit(input rob_pkg::rob_commit_t got, input rob_pkg::rob_commit_t exp);
        if (got !== exp) begin
            $display("** Error: commit got %h expected %h at %0t", got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [`PC_W-1:0] got, input logic [`PC_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error: redirect_pc got %h expected %h at %0t", got, exp, $time);
            errors++;
        end
    endtask

    function automatic bit cond_met(input int what);
        if (what == WAIT_FULL) begin
            return full === 1'b1;
        end
        return order.size() == 0 && !sq_pend;
    endfunction

    task automatic wait_for(input int what, input string msg);
        int n;
        n = 0;
        @(posedge clk);
        #2;
        while (!cond_met(what) && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!cond_met(what)) begin
            $display("timeout while waiting for %s", msg);
            $display("ERRORS FOUND");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    // random dispatch and out-of-order completion
    initial begin : stimulus
        int idx;
        rob_pkg::rob_tag_t t;
        dispatch_valid = 1'b0;
        dispatch = '0;
        complete_valid = 1'b0;
        complete = '0;
        forever begin
            @(posedge clk);
            #1;
            dispatch_valid = dis_en && (($random(seed) & 3) != 0);
            dispatch.rd = rob_pkg::reg_name_t'($random(seed));
            dispatch.is_store = st_en && (($random(seed) & 3) == 0);
            dispatch.pred_taken = ($random(seed) & 1) != 0;
            complete_valid = 1'b0;
            if (cmp_en && order.size() > keep_head) begin
                idx = keep_head
                    + ($random(seed) & 32'h7fffffff) % (order.size() - keep_head);
                t = order[idx];
                complete_valid = ($random(seed) & 3) != 0;
                complete.tag = t;
                complete.data = $random(seed);
                complete.target = $random(seed);
                complete.taken = m_ent[t].pred_taken;
                if (!m_ent[t].is_store && ($random(seed) & 32'h7fffffff) % 100 < mp_rate) begin
                    complete.taken = ~m_ent[t].pred_taken;
                end
            end
        end
    end

    always @(negedge clk) begin : model_check
        bit sq;
        bit ret;
        bit mp;
        bit acc;
        rob_pkg::rob_tag_t h;
        rob_pkg::rob_commit_t exp_c;
        if (rst_n) begin
            sq = sq_pend || flush;
            h = order.size() > 0 ? order[0] : '0;
            ret = !sq && order.size() > 0 && m_ent[h].done;
            mp = ret && !m_ent[h].is_store && (m_ent[h].taken != m_ent[h].pred_taken);
            check_flag("full", full, order.size() == `ROB_DEPTH && !sq);
            check_tag("alloc_tag", alloc_tag, m_wr);
            check_flag("commit_valid", commit_valid, ret && !m_ent[h].is_store);
            check_flag("store_valid", store_valid, ret && m_ent[h].is_store);
            check_flag("redirect_valid", redirect_valid, mp);
            if (ret && !m_ent[h].is_store) begin
                exp_c = '{rd: m_ent[h].rd, data: m_ent[h].data, tag: h};
                check_commit(commit, exp_c);
            end
            if (ret && m_ent[h].is_store) begin
                check_tag("store_tag", store_tag, h);
            end
            if (mp) begin
                check_pc(redirect_pc, m_ent[h].target);
            end
            // strobes as seen on the DUT outputs
            if (commit_valid || store_valid) begin
                commits++;
            end
            if (redirect_valid) begin
                redirects++;
            end
            acc = dispatch_valid && !sq && order.size() < `ROB_DEPTH;
            if (sq) begin
                order.delete();
                m_occ = '0;
                m_wr = '0;
            end else begin
                if (complete_valid && m_occ[complete.tag] && !m_ent[complete.tag].done) begin
                    m_ent[complete.tag].data = complete.data;
                    m_ent[complete.tag].taken = complete.taken;
                    m_ent[complete.tag].target = complete.target;
                    m_ent[complete.tag].done = 1'b1;
                end
                if (acc) begin
                    m_ent[m_wr] = '{rd: dispatch.rd, is_store: dispatch.is_store,
                                    pred_taken: dispatch.pred_taken, default: '0};
                    m_occ[m_wr] = 1'b1;
                    order.push_back(m_wr);
                    m_wr = rob_pkg::rob_tag_t'(m_wr + 1'b1);
                end
                if (ret) begin
                    void'(order.pop_front());
                    m_occ[h] = 1'b0;
                    m_ent[h].done = 1'b0;
                end
            end
            sq_pend = mp;
        end
    end

    initial begin : main_flow
        rob_pkg::rob_tag_t start_tag;
        int mark;
        rst_n = 1'b0;
        flush = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #1;
        check_flag("full", full, 1'b0);
        check_flag("commit_valid", commit_valid, 1'b0);
        check_flag("store_valid", store_valid, 1'b0);
        check_flag("redirect_valid", redirect_valid, 1'b0);
        check_tag("alloc_tag", alloc_tag, '0);
        end_test("reset");

        dis_en = 1'b1;
        cmp_en = 1'b1;
        st_en = 1'b1;
        repeat (300) @(posedge clk);
        dis_en = 1'b0;
        wait_for(WAIT_EMPTY, "in-order drain");
        if (commits == 0) begin
            $display("no instruction committed during random run");
            errors++;
        end
        end_test("in-order commit");

        // fill with no completions, then keep knocking
        start_tag = m_wr;
        cmp_en = 1'b0;
        dis_en = 1'b1;
        wait_for(WAIT_FULL, "full");
        repeat (6) @(posedge clk);
        #2;
        check_flag("full", full, 1'b1);
        check_tag("alloc_tag", alloc_tag, start_tag);
        dis_en = 1'b0;
        cmp_en = 1'b1;
        wait_for(WAIT_EMPTY, "drain after full");
        end_test("full");

        // first commit is a mispredicting non-store
        cmp_en = 1'b0;
        st_en = 1'b0;
        mp_rate = 100;
        dis_en = 1'b1;
        repeat (10) @(posedge clk);
        dis_en = 1'b0;
        mark = commits;
        cmp_en = 1'b1;
        wait_for(WAIT_EMPTY, "squash after mispredict");
        if (commits != mark + 1 || redirects == 0) begin
            $display("expected one commit with redirect, saw %0d commits", commits - mark);
            errors++;
        end
        check_tag("alloc_tag", alloc_tag, '0);
        st_en = 1'b1;
        mp_rate = 15;
        dis_en = 1'b1;
        repeat (300) @(posedge clk);
        dis_en = 1'b0;
        wait_for(WAIT_EMPTY, "drain with mispredicts")
;
        end_test("mispredict");

        // head stays pending while younger entries finish
        mp_rate = 0;
        keep_head = 1;
        dis_en = 1'b1;
        repeat (8) @(posedge clk);
        dis_en = 1'b0;
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        #1;
        check_tag("alloc_tag", alloc_tag, '0);
        keep_head = 0;
        mark = commits;
        repeat (6) @(posedge clk);
        if (commits != mark) begin
            $display("commit seen after flush with nothing dispatched");
            errors++;
        end
        dis_en = 1'b1;
        repeat (40) @(posedge clk);
        dis_en = 1'b0;
        wait_for(WAIT_EMPTY, "drain after flush");
        end_test("flush");

        errors += rob_top_i.rob_commit_i.rob_asserts_i.fail_count;
        $display("%0d tests, %0d failed, %0d errors", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/rob_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_asserts (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic squash,
    input wire logic commit_valid,
    input wire logic store_valid,
    input wire logic redirect_valid
);

    int fail_count = 0;

    // register write and store release are exclusive
    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(commit_valid && store_valid))
        else begin
            fail_count++;
            $error("commit_valid and store_valid high together");
        end

    // a mispredicted head still writes its register
    redirect_with_commit: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> commit_valid)
        else begin
            fail_count++;
            $error("redirect_valid without commit_valid");
        end

    quiet_in_squash: assert property (@(posedge clk) disable iff (!rst_n)
        squash |-> !(commit_valid || store_valid || redirect_valid))
        else begin
            fail_count++;
            $error("strobe raised while squash is high");
        end

endmodule

bind rob_commit rob_asserts rob_asserts_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .squash         (squash),
    .commit_valid   (commit_valid),
    .store_valid    (store_valid),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

// ==== hw/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  flush,
    input  wire logic                  dispatch_valid,
    input  rob_pkg::rob_dispatch_t     dispatch,
    output logic                       full,
    output rob_pkg::rob_tag_t          alloc_tag,
    input  wire logic                  complete_valid,
    input  rob_pkg::rob_complete_t     complete,
    output logic                       commit_valid,
    output rob_pkg::rob_commit_t       commit,
    output logic                       store_valid,
    output rob_pkg::rob_tag_t          store_tag,
    output logic                       redirect_valid,
    output logic [`PC_W-1:0]           redirect_pc
);

    logic                 alloc_we;
    logic                 retire;
    logic                 squash;
    logic                 head_valid;
    rob_pkg::rob_tag_t    head_tag;
    rob_pkg::rob_entry_t  head_entry;

    rob_tag_alloc rob_tag_alloc_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .retire         (retire),
        .squash         (squash),
        .full           (full),
        .alloc_tag      (alloc_tag),
        .alloc_we       (alloc_we)
    );

    rob_entry_table rob_entry_table_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc_we       (alloc_we),
        .alloc_tag      (alloc_tag),
        .dispatch       (dispatch),
        .complete_valid (complete_valid),
        .complete       (complete),
        .head_tag       (head_tag),
        .retire         (retire),
        .squash         (squash),
        .head_entry     (head_entry),
        .head_valid     (head_valid)
    );

    rob_commit rob_commit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .head_entry     (head_entry),
        .head_valid     (head_valid),
        .head_tag       (head_tag),
        .retire         (retire),
        .squash         (squash),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .store_valid    (store_valid),
        .store_tag      (store_tag),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== hw/rob_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_commit (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  flush,
    input  rob_pkg::rob_entry_t        head_entry,
    input  wire logic                  head_valid,
    output rob_pkg::rob_tag_t          head_tag,
    output logic                       retire,
    output logic                       squash,
    output logic                       commit_valid,
    output rob_pkg::rob_commit_t       commit,
    output logic                       store_valid,
    output rob_pkg::rob_tag_t          store_tag,
    output logic                       redirect_valid,
    output logic [`PC_W-1:0]           redirect_pc
);

    rob_pkg::rob_tag_t head_ptr;
    logic              squash_q;
    logic              mispredict;

    assign squash = squash_q | flush;
    assign retire = head_valid & head_entry.done & ~squash;

    // stores carry no branch outcome
    assign mispredict = retire & ~head_entry.is_store
                      & (head_entry.taken != head_entry.pred_taken);

    assign commit_valid = retire & ~head_entry.is_store;
    assign store_valid  = retire & head_entry.is_store;

    assign commit.rd   = head_entry.rd;
    assign commit.data = head_entry.data;
    assign commit.tag  = head_ptr;

    assign store_tag      = head_ptr;
    assign head_tag       = head_ptr;
    assign redirect_valid = mispredict;
    assign redirect_pc    = head_entry.target;

    // in-order retire pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else if (squash) begin
            head_ptr <= '0;
        end else if (retire) begin
            head_ptr <= rob_pkg::rob_tag_t'(head_ptr + 1'b1);
        end
    end

    // one-cycle squash after a mispredicted commit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            squash_q <= 1'b0;
        end else begin
            squash_q <= mispredict;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rob_entry_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_entry_table (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  alloc_we,
    input  rob_pkg::rob_tag_t          alloc_tag,
    input  rob_pkg::rob_dispatch_t     dispatch,
    input  wire logic                  complete_valid,
    input  rob_pkg::rob_complete_t     complete,
    input  rob_pkg::rob_tag_t          head_tag,
    input  wire logic                  retire,
    input  wire logic                  squash,
    output rob_pkg::rob_entry_t        head_entry,
    output logic                       head_valid
);

    rob_pkg::rob_entry_t     entries [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]   occupied;
    logic                    complete_we;

    // late or duplicate results are dropped
    assign complete_we = complete_valid & ~squash
                       & occupied[complete.tag]
                       & ~entries[complete.tag].done;

    // one occupied bit per tag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
        end else if (squash) begin
            occupied <= '0;
        end else begin
            if (alloc_we) begin
                occupied[alloc_tag] <= 1'b1;
            end
            if (retire) begin
                occupied[head_tag] <= 1'b0;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_we) begin
            entries[alloc_tag] <= '{
                rd:         dispatch.rd,
                is_store:   dispatch.is_store,
                pred_taken: dispatch.pred_taken,
                done:       1'b0,
                taken:      1'b0,
                data:       '0,
                target:     '0
            };
        end
        if (complete_we) begin
            entries[complete.tag].data   <= complete.data;
            entries[complete.tag].taken  <= complete.taken;
            entries[complete.tag].target <= complete.target;
            entries[complete.tag].done   <= 1'b1;
        end
        // done is cleared so a stale result cannot look finished
        if (retire) begin
            entries[head_tag].done <= 1'b0;
        end
    end

    // head read is combinational for same-cycle commit
    assign head_entry = entries[head_tag];
    assign head_valid = occupied[head_tag];

endmodule

`default_nettype wire

// ==== hw/rob_tag_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_cfg.svh"

module rob_tag_alloc (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              dispatch_valid,
    input  wire logic              retire,
    input  wire logic              squash,
    output logic                   full,
    output rob_pkg::rob_tag_t      alloc_tag,
    output logic                   alloc_we
);

    rob_pkg::rob_tag_t   wr_ptr;
    logic [`ROB_TAG_W:0] count;
    logic                at_depth;

    assign at_depth = (count == (`ROB_TAG_W+1)'(`ROB_DEPTH));

    // full drops while a squash is pending
    assign full      = at_depth & ~squash;
    assign alloc_tag = wr_ptr;
    assign alloc_we  = dispatch_valid & ~at_depth & ~squash;

    // depth is a power of two, so the pointer wraps by overflow
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (squash) begin
            wr_ptr <= '0;
        end else if (alloc_we) begin
            wr_ptr <= rob_pkg::rob_tag_t'(wr_ptr + 1'b1);
        end
    end

    // accept and retire may land in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (squash) begin
            count <= '0;
        end else begin
            case ({alloc_we, retire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/rob_pkg.sv ====
`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [`REG_NAME_W-1:0] reg_name_t;

    // recorded at dispatch
    typedef struct packed {
        reg_name_t rd;
        logic is_store;
        logic pred_taken;
    } rob_dispatch_t;

    // reported by execute, out of order
    typedef struct packed {
        rob_tag_t tag;
        logic [`XLEN-1:0] data;
        logic taken;
        logic [`PC_W-1:0] target;
    } rob_complete_t;

    // register file write at commit
    typedef struct packed {
        reg_name_t rd;
        logic [`XLEN-1:0] data;
        rob_tag_t tag;
    } rob_commit_t;

    typedef struct packed {
        reg_name_t rd;
        logic is_store;
        logic pred_taken;
        logic done;
        logic taken;
        logic [`XLEN-1:0] data;
        logic [`PC_W-1:0] target;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== hw/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// datapath widths
`define XLEN 32
`define PC_W 32

// architectural register name
`define REG_NAME_W 5

`endif
